// File: source/mem_if_config.svh
`ifndef MEM_IF_CONFIG_SVH
`define MEM_IF_CONFIG_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

// internal ram word and external data byte
`define MEM_IF_DATA_W 8
// movx address space
`define MEM_IF_EXT_ADDR_W 16
// bank register address, two bank bits and three register bits
`define MEM_IF_RN_W 5

////////////////////////////////////////
// fixed sfr addresses
////////////////////////////////////////

`define MEM_IF_SFR_B 8'hf0
`define MEM_IF_SFR_ACC 8'he0
`define MEM_IF_SFR_PSW 8'hd0
`define MEM_IF_SFR_DPTR_LO 8'h82

`endif

// File: source/mem_if_ram_pkg.sv
`default_nettype none

`include "mem_if_config.svh"

package mem_if_ram_pkg;

  // internal ram or sfr address
  typedef logic [`MEM_IF_DATA_W-1:0] iram_addr_t;
  // register in the active bank
  typedef logic [`MEM_IF_RN_W-1:0] rn_addr_t;

  // read address sources, decoder encoding
  typedef enum logic [2:0] {
    RD_RN   = 3'd0,
    RD_RI   = 3'd1,
    RD_DIR  = 3'd2,
    RD_SP   = 3'd3,
    RD_B    = 3'd4,
    RD_DPTR = 3'd5,
    RD_PSW  = 3'd6,
    RD_ACC  = 3'd7
  } rd_sel_e;

  // write address sources
  // codes 6 and 7 are unused, fall back to rn
  typedef enum logic [2:0] {
    WR_RN   = 3'd0,
    WR_RI   = 3'd1,
    WR_DIR  = 3'd2,
    WR_SP   = 3'd3,
    WR_DIR2 = 3'd4,
    WR_B    = 3'd5
  } wr_sel_e;

  // everything an address can be taken from
  typedef struct packed {
    rn_addr_t   rn;
    iram_addr_t ri;
    iram_addr_t sp;
    iram_addr_t sp_w;
    iram_addr_t imm;
    iram_addr_t imm2;
  } reg_src_t;

  // addresses and indirect flags toward the ram
  typedef struct packed {
    iram_addr_t rd_addr;
    iram_addr_t wr_addr;
    logic       rd_ind;
    logic       wr_ind;
  } iram_ctrl_t;

endpackage

`default_nettype wire

// File: source/mem_if_ext_pkg.sv
`default_nettype none

`include "mem_if_config.svh"

package mem_if_ext_pkg;

  ////////////////////////////////////////
  // data and address
  ////////////////////////////////////////

  // one data byte, ram or external
  typedef logic [`MEM_IF_DATA_W-1:0] byte_t;
  // external data address
  typedef logic [`MEM_IF_EXT_ADDR_W-1:0] ext_addr_t;

  ////////////////////////////////////////
  // memory actions from the decoder
  ////////////////////////////////////////

  // only the four movx codes start a data access
  // code fetch and the reserved codes stay idle on this side
  typedef enum logic [2:0] {
    MA_NONE   = 3'd0,
    MA_DPTR_R = 3'd1,
    MA_DPTR_W = 3'd2,
    MA_RI_R   = 3'd3,
    MA_RI_W   = 3'd4,
    MA_CODE   = 3'd5,
    MA_RSV6   = 3'd6,
    MA_RSV7   = 3'd7
  } mem_act_e;

  ////////////////////////////////////////
  // registered external request
  ////////////////////////////////////////

  // we high for movx writes
  // dat is acc for writes, zero for reads
  typedef struct packed {
    logic      we;
    ext_addr_t adr;
    byte_t     dat;
  } ext_req_t;

endpackage

`default_nettype wire

// File: source/ram_addr_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_if_config.svh"

module ram_addr_select (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire mem_if_ram_pkg::rd_sel_e   rd_sel_i,
  input  wire mem_if_ram_pkg::wr_sel_e   wr_sel_i,
  input  wire mem_if_ram_pkg::reg_src_t  src_i,
  input  wire mem_if_ext_pkg::byte_t     in_ram_i,
  input  wire mem_if_ext_pkg::byte_t     sfr_i,
  input  wire logic                      bit_in_i,
  input  wire logic                      sfr_bit_i,
  output mem_if_ram_pkg::iram_ctrl_t     iram_o,
  output mem_if_ext_pkg::byte_t          iram_out_o,
  output logic                           bit_out_o
);

  mem_if_ram_pkg::iram_addr_t rd_addr;
  mem_if_ram_pkg::iram_addr_t wr_addr;
  logic                       wr_ind;
  // read side state of the previous cycle
  logic                       rd_ind_q;
  logic                       rd_hi_q;
  // operands one cycle old, used by the write address
  mem_if_ram_pkg::rn_addr_t   rn_q;
  mem_if_ram_pkg::iram_addr_t ri_q;
  mem_if_ram_pkg::iram_addr_t imm_q;
  mem_if_ram_pkg::iram_addr_t imm2_q;

  ////////////////////////////////////////
  // read address
  ////////////////////////////////////////

  always_comb begin
    unique case (rd_sel_i)
      // rn already holds the bank bits
      mem_if_ram_pkg::RD_RN:   rd_addr = mem_if_ram_pkg::iram_addr_t'(src_i.rn);
      mem_if_ram_pkg::RD_RI:   rd_addr = src_i.ri;
      mem_if_ram_pkg::RD_DIR:  rd_addr = src_i.imm;
      mem_if_ram_pkg::RD_SP:   rd_addr = src_i.sp;
      // fixed sfr reads
      mem_if_ram_pkg::RD_B:    rd_addr = `MEM_IF_SFR_B;
      mem_if_ram_pkg::RD_DPTR: rd_addr = `MEM_IF_SFR_DPTR_LO;
      mem_if_ram_pkg::RD_PSW:  rd_addr = `MEM_IF_SFR_PSW;
      mem_if_ram_pkg::RD_ACC:  rd_addr = `MEM_IF_SFR_ACC;
    endcase
  end

  // indirect flag and top address bit, one cycle late like the ram data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ind_q <= 1'b0;
      rd_hi_q  <= 1'b0;
    end else begin
      rd_ind_q <= (rd_sel_i == mem_if_ram_pkg::RD_RI) ||
                  (rd_sel_i == mem_if_ram_pkg::RD_SP);
      rd_hi_q  <= rd_addr[`MEM_IF_DATA_W-1];
    end
  end

  ////////////////////////////////////////
  // write address
  ////////////////////////////////////////

  // write lags the read by a cycle, so keep the operands
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rn_q   <= '0;
      ri_q   <= '0;
      imm_q  <= '0;
      imm2_q <= '0;
    end else begin
      rn_q   <= src_i.rn;
      ri_q   <= src_i.ri;
      imm_q  <= src_i.imm;
      imm2_q <= src_i.imm2;
    end
  end

  always_comb begin
    case (wr_sel_i)
      mem_if_ram_pkg::WR_RI:   wr_addr = ri_q;
      mem_if_ram_pkg::WR_DIR:  wr_addr = imm_q;
      // sp_w is already the updated stack pointer
      mem_if_ram_pkg::WR_SP:   wr_addr = src_i.sp_w;
      mem_if_ram_pkg::WR_DIR2: wr_addr = imm2_q;
      mem_if_ram_pkg::WR_B:    wr_addr = `MEM_IF_SFR_B;
      // rn and the unused codes
      default:                 wr_addr = mem_if_ram_pkg::iram_addr_t'(rn_q);
    endcase
  end

  // indirect write goes to ram even above 7f
  assign wr_ind = (wr_sel_i == mem_if_ram_pkg::WR_RI) ||
                  (wr_sel_i == mem_if_ram_pkg::WR_SP);

  assign iram_o = '{rd_addr: rd_addr, wr_addr: wr_addr, rd_ind: rd_ind_q, wr_ind: wr_ind};

  ////////////////////////////////////////
  // read data merge
  ////////////////////////////////////////

  // direct access above 7f reads the sfr file
  always_comb begin
    if (rd_hi_q && !rd_ind_q) begin
      iram_out_o = sfr_i;
      bit_out_o  = sfr_bit_i;
    end else begin
      iram_out_o = in_ram_i;
      bit_out_o  = bit_in_i;
    end
  end

endmodule

`default_nettype wire

// File: source/ext_data_access.sv
`timescale 1ns/1ns
`default_nettype none

module ext_data_access (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire mem_if_ext_pkg::mem_act_e  mem_act_i,
  input  wire mem_if_ext_pkg::ext_addr_t dptr_i,
  input  wire mem_if_ext_pkg::byte_t     ri_i,
  input  wire mem_if_ext_pkg::byte_t     acc_i,
  input  wire logic                      dack_i,
  input  wire mem_if_ext_pkg::byte_t     ddat_i,
  output mem_if_ext_pkg::ext_req_t       ext_req_o,
  output logic                           dstb_o,
  output logic                           mem_wait_o,
  output mem_if_ext_pkg::byte_t          rdata_o,
  output logic                           rdata_valid_o
);

  // decoded action
  logic                      act_go;
  logic                      act_wr;
  logic                      act_dptr;
  // request registers
  logic                      we_q;
  mem_if_ext_pkg::ext_addr_t adr_q;
  mem_if_ext_pkg::byte_t     dat_q;

  ////////////////////////////////////////
  // movx decode
  ////////////////////////////////////////

  always_comb begin
    act_go   = 1'b1;
    act_wr   = 1'b0;
    act_dptr = 1'b0;
    case (mem_act_i)
      mem_if_ext_pkg::MA_DPTR_R: act_dptr = 1'b1;
      mem_if_ext_pkg::MA_DPTR_W: begin
        act_dptr = 1'b1;
        act_wr   = 1'b1;
      end
      mem_if_ext_pkg::MA_RI_R:   act_dptr = 1'b0;
      mem_if_ext_pkg::MA_RI_W:   act_wr   = 1'b1;
      // none, code and reserved
      default:                   act_go   = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // strobe and wait
  ////////////////////////////////////////

  // ack wins over a new action in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dstb_o     <= 1'b0;
      we_q       <= 1'b0;
      mem_wait_o <= 1'b0;
    end else if (dack_i) begin
      dstb_o     <= 1'b0;
      we_q       <= 1'b0;
      mem_wait_o <= 1'b0;
    end else if (act_go) begin
      dstb_o     <= 1'b1;
      we_q       <= act_wr;
      mem_wait_o <= 1'b1;
    end
  end

  // address and data stay after the access ends
  always_ff @(posedge clk) begin
    if (!dack_i && act_go) begin
      // ri reaches only the first 256 bytes
      adr_q <= act_dptr ? dptr_i : mem_if_ext_pkg::ext_addr_t'(ri_i);
      dat_q <= act_wr ? acc_i : '0;
    end
  end

  assign ext_req_o = '{we: we_q, adr: adr_q, dat: dat_q};

  ////////////////////////////////////////
  // read return
  ////////////////////////////////////////

  // data held until the next ack, valid for one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata_o       <= '0;
      rdata_valid_o <= 1'b0;
    end else begin
      rdata_valid_o <= dack_i;
      if (dack_i) begin
        rdata_o <= ddat_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mem_if_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_if_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  // decoder side
  input  wire mem_if_ram_pkg::rd_sel_e   rd_sel_i,
  input  wire mem_if_ram_pkg::wr_sel_e   wr_sel_i,
  input  wire mem_if_ram_pkg::reg_src_t  src_i,
  input  wire mem_if_ext_pkg::mem_act_e  mem_act_i,
  input  wire mem_if_ext_pkg::ext_addr_t dptr_i,
  input  wire mem_if_ext_pkg::byte_t     acc_i,
  // internal ram and sfr file
  input  wire mem_if_ext_pkg::byte_t     in_ram_i,
  input  wire logic                      bit_in_i,
  input  wire mem_if_ext_pkg::byte_t     sfr_i,
  input  wire logic                      sfr_bit_i,
  output mem_if_ram_pkg::iram_ctrl_t     iram_o,
  output mem_if_ext_pkg::byte_t          iram_out_o,
  output logic                           bit_out_o,
  // external data bus
  input  wire logic                      dack_i,
  input  wire mem_if_ext_pkg::byte_t     ddat_i,
  output mem_if_ext_pkg::ext_req_t       ext_req_o,
  output logic                           dstb_o,
  // core side status
  output logic                           mem_wait_o,
  output mem_if_ext_pkg::byte_t          rdata_o,
  output logic                           rdata_valid_o
);

  ////////////////////////////////////////
  // internal ram addressing
  ////////////////////////////////////////

  ram_addr_select u_ram_addr_select (
    .clk        (clk),
    .rst        (rst),
    .rd_sel_i   (rd_sel_i),
    .wr_sel_i   (wr_sel_i),
    .src_i      (src_i),
    .in_ram_i   (in_ram_i),
    .sfr_i      (sfr_i),
    .bit_in_i   (bit_in_i),
    .sfr_bit_i  (sfr_bit_i),
    .iram_o     (iram_o),
    .iram_out_o (iram_out_o),
    .bit_out_o  (bit_out_o)
  );

  ////////////////////////////////////////
  // external data memory
  ////////////////////////////////////////

  // ri shared with the ram side for @ri movx
  ext_data_access u_ext_data_access (
    .clk           (clk),
    .rst           (rst),
    .mem_act_i     (mem_act_i),
    .dptr_i        (dptr_i),
    .ri_i          (src_i.ri),
    .acc_i         (acc_i),
    .dack_i        (dack_i),
    .ddat_i        (ddat_i),
    .ext_req_o     (ext_req_o),
    .dstb_o        (dstb_o),
    .mem_wait_o    (mem_wait_o),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

endmodule

`default_nettype wire

// File: test/mem_if_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module mem_if_assertions (
  input wire logic clk,
  input wire logic rst,
  input wire logic dstb_i,
  input wire logic mem_wait_i,
  input wire logic we_i,
  input wire logic rdata_valid_i
);

  // one counter per property, summed for the testbench
  int unsigned stb_fails = 0;
  int unsigned we_fails = 0;
  int unsigned valid_fails = 0;
  int unsigned fail_cnt;

  assign fail_cnt = stb_fails + we_fails + valid_fails;

  // core stalls for as long as the strobe is out
  stb_holds_wait: assert property (@(posedge clk) disable iff (rst) dstb_i |-> mem_wait_i)
    else begin
      $error("dstb_o high while mem_wait_o is low");
      stb_fails++;
    end

  // write enable only inside a strobe
  we_in_stb: assert property (@(posedge clk) disable iff (rst) we_i |-> dstb_i)
    else begin
      $error("ext_req_o.we high outside a strobe");
      we_fails++;
    end

  // one valid cycle per acknowledge
  valid_single: assert property (@(posedge clk) disable iff (rst) rdata_valid_i |=> !rdata_valid_i)
    else begin
      $error("rdata_valid_o high for two cycles in a row");
      valid_fails++;
    end

endmodule

bind mem_if_top mem_if_assertions u_mem_if_assertions (
  .clk           (clk),
  .rst           (rst),
  .dstb_i        (dstb_o),
  .mem_wait_i    (mem_wait_o),
  .we_i          (ext_req_o.we),
  .rdata_valid_i (rdata_valid_o)
);

`default_nettype wire

// File: test/mem_if_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_if_config.svh"

module mem_if_tb;

  // address cycles and movx accesses to cover
  localparam int ADDR_CYCLES = 1500;
  localparam int ACCESSES = 100;
  // tests need about 2000 cycles, limit at twice that
  localparam int CYCLE_LIMIT = 4000;

  logic                       clk;
  logic                       rst;
  mem_if_ram_pkg::rd_sel_e    rd_sel;
  mem_if_ram_pkg::wr_sel_e    wr_sel;
  mem_if_ram_pkg::reg_src_t   src;
  mem_if_ext_pkg::mem_act_e   mem_act;
  mem_if_ext_pkg::ext_addr_t  dptr;
  mem_if_ext_pkg::byte_t      acc;
  mem_if_ext_pkg::byte_t      in_ram;
  logic                       bit_in;
  mem_if_ext_pkg::byte_t      sfr;
  logic                       sfr_bit;
  logic                       dack;
  mem_if_ext_pkg::byte_t      ddat;
  mem_if_ram_pkg::iram_ctrl_t iram;
  mem_if_ext_pkg::byte_t      iram_out;
  logic                       bit_out;
  mem_if_ext_pkg::ext_req_t   ext_req;
  logic                       dstb;
  logic                       mem_wait;
  mem_if_ext_pkg::byte_t      rdata;
  logic                       rdata_valid;

  integer      seed;
  logic [31:0] rnd;
  int          cyc_total = 0;
  int          cyc_n;
  int          check_errors;
  int unsigned asrt_fails;

  // ram side model, values of the previous cycle
  mem_if_ram_pkg::rd_sel_e    prev_rd_sel;
  logic                       prev_hi;
  mem_if_ram_pkg::rn_addr_t   prev_rn;
  mem_if_ram_pkg::iram_addr_t prev_ri;
  mem_if_ram_pkg::iram_addr_t prev_imm;
  mem_if_ram_pkg::iram_addr_t prev_imm2;
  // external side model, registered outputs expected now
  logic                       m_stb;
  logic                       m_we;
  mem_if_ext_pkg::ext_addr_t  m_adr;
  mem_if_ext_pkg::byte_t      m_dat;
  logic                       m_req_known;
  mem_if_ext_pkg::byte_t      m_rdata;
  logic                       m_rvalid;
  // responder state
  logic                       busy;
  logic                       ack_armed;
  logic [2:0]                 ack_cnt;
  int                         issued;
  int                         acked;
  // dut responses counted over the run
  logic                       last_dstb;
  int                         stb_starts;
  int                         valid_pulses;

  mem_if_top i_mem_if_top (
    .clk           (clk),
    .rst           (rst),
    .rd_sel_i      (rd_sel),
    .wr_sel_i      (wr_sel),
    .src_i         (src),
    .mem_act_i     (mem_act),
    .dptr_i        (dptr),
    .acc_i         (acc),
    .in_ram_i      (in_ram),
    .bit_in_i      (bit_in),
    .sfr_i         (sfr),
    .sfr_bit_i     (sfr_bit),
    .iram_o        (iram),
    .iram_out_o    (iram_out),
    .bit_out_o     (bit_out),
    .dack_i        (dack),
    .ddat_i        (ddat),
    .ext_req_o     (ext_req),
    .dstb_o        (dstb),
    .mem_wait_o    (mem_wait),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc_total = cyc_total + 1;
    if (cyc_total >= CYCLE_LIMIT) begin
      $display("timeout, run not finished after %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // read address as the decoder selects it
  function automatic mem_if_ram_pkg::iram_addr_t exp_rd_addr(
    input mem_if_ram_pkg::rd_sel_e sel, input mem_if_ram_pkg::reg_src_t s);
    case (sel)
      mem_if_ram_pkg::RD_RN:   return {3'b000, s.rn};
      mem_if_ram_pkg::RD_RI:   return s.ri;
      mem_if_ram_pkg::RD_DIR:  return s.imm;
      mem_if_ram_pkg::RD_SP:   return s.sp;
      mem_if_ram_pkg::RD_B:    return `MEM_IF_SFR_B;
      mem_if_ram_pkg::RD_DPTR: return `MEM_IF_SFR_DPTR_LO;
      mem_if_ram_pkg::RD_PSW:  return `MEM_IF_SFR_PSW;
      default:                 return `MEM_IF_SFR_ACC;
    endcase
  endfunction

  // write address, operands one cycle old except sp_w
  function automatic mem_if_ram_pkg::iram_addr_t exp_wr_addr(
    input mem_if_ram_pkg::wr_sel_e sel, input mem_if_ram_pkg::iram_addr_t sp_w);
    case (sel)
      mem_if_ram_pkg::WR_RI:   return prev_ri;
      mem_if_ram_pkg::WR_DIR:  return prev_imm;
      mem_if_ram_pkg::WR_SP:   return sp_w;
      mem_if_ram_pkg::WR_DIR2: return prev_imm2;
      mem_if_ram_pkg::WR_B:    return `MEM_IF_SFR_B;
      default:                 return {3'b000, prev_rn};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus and checks per cycle
  ////////////////////////////////////////

  task automatic drive_inputs(input bit allow_issue);
    logic [2:0] act_code;
    rnd = $random(seed);
    rd_sel = mem_if_ram_pkg::rd_sel_e'(rnd[2:0]);
    wr_sel = mem_if_ram_pkg::wr_sel_e'(rnd[5:3]);
    bit_in = rnd[6];
    sfr_bit = rnd[7];
    in_ram = rnd[15:8];
    sfr = rnd[23:16];
    src.rn = rnd[28:24];
    rnd = $random(seed);
    src.ri = rnd[7:0];
    src.sp = rnd[15:8];
    src.sp_w = rnd[23:16];
    src.imm = rnd[31:24];
    rnd = $random(seed);
    src.imm2 = rnd[7:0];
    acc = rnd[15:8];
    dptr = rnd[31:16];
    rnd = $random(seed);
    ddat = rnd[7:0];
    // none, code or reserved unless an access starts
    act_code = (rnd[9:8] == 2'd0) ? 3'd0 : {1'b1, rnd[9:8]};
    dack = 1'b0;
    if (busy && dstb) begin
      // acknowledge 1 to 4 cycles into the strobe
      if (!ack_armed) begin
        ack_armed = 1'b1;
        ack_cnt = {1'b0, rnd[11:10]} + 3'd1;
      end
      if (ack_cnt == 3'd1) begin
        dack = 1'b1;
        busy = 1'b0;
        ack_armed = 1'b0;
        acked++;
      end else begin
        ack_cnt = ack_cnt - 3'd1;
      end
    end else if (allow_issue && !busy && !dstb && issued < ACCESSES && rnd[13:12] != 2'd0) begin
      // one of the four movx actions
      act_code = {1'b0, rnd[15:14]} + 3'd1;
      busy = 1'b1;
      issued++;
    end
    mem_act = mem_if_ext_pkg::mem_act_e'(act_code);
  endtask

  task automatic check_outputs();
    logic exp_rd_ind;
    logic exp_wr_ind;
    logic use_sfr;
    exp_rd_ind = (prev_rd_sel == mem_if_ram_pkg::RD_RI) || (prev_rd_sel == mem_if_ram_pkg::RD_SP);
    exp_wr_ind = (wr_sel == mem_if_ram_pkg::WR_RI) || (wr_sel == mem_if_ram_pkg::WR_SP);
    use_sfr = prev_hi && !exp_rd_ind;
    check_value("iram_o.rd_addr", 16'(iram.rd_addr), 16'(exp_rd_addr(rd_sel, src)));
    check_value("iram_o.rd_ind", 16'(iram.rd_ind), 16'(exp_rd_ind));
    check_value("iram_o.wr_ind", 16'(iram.wr_ind), 16'(exp_wr_ind));
    check_value("iram_o.wr_addr", 16'(iram.wr_addr), 16'(exp_wr_addr(wr_sel, src.sp_w)));
    check_value("iram_out_o", 16'(iram_out), 16'(use_sfr ? sfr : in_ram));
    check_value("bit_out_o", 16'(bit_out), 16'(use_sfr ? sfr_bit : bit_in));
    check_value("dstb_o", 16'(dstb), 16'(m_stb));
    check_value("mem_wait_o", 16'(mem_wait), 16'(m_stb));
    check_value("ext_req_o.we", 16'(ext_req.we), 16'(m_we));
    // adr and dat undefined until the first access
    if (m_req_known) begin
      check_value("ext_req_o.adr", ext_req.adr, m_adr);
      check_value("ext_req_o.dat", 16'(ext_req.dat), 16'(m_dat));
    end
    check_value("rdata_valid_o", 16'(rdata_valid), 16'(m_rvalid));
    check_value("rdata_o", 16'(rdata), 16'(m_rdata));
    // strobes and read returns as the dut shows them
    if (dstb && !last_dstb) begin
      stb_starts++;
    end
    if (rdata_valid) begin
      valid_pulses++;
    end
    last_dstb = dstb;
  endtask

  // state after the coming rising edge
  task automatic advance_model();
    mem_if_ram_pkg::iram_addr_t rd_now;
    logic is_wr;
    rd_now = exp_rd_addr(rd_sel, src);
    prev_rd_sel = rd_sel;
    prev_hi = rd_now[7];
    prev_rn = src.rn;
    prev_ri = src.ri;
    prev_imm = src.imm;
    prev_imm2 = src.imm2;
    is_wr = (mem_act == mem_if_ext_pkg::MA_DPTR_W) || (mem_act == mem_if_ext_pkg::MA_RI_W);
    m_rvalid = dack;
    if (dack) begin
      m_rdata = ddat;
      m_stb = 1'b0;
      m_we = 1'b0;
    end else if (mem_act inside {mem_if_ext_pkg::MA_DPTR_R, mem_if_ext_pkg::MA_DPTR_W,
                                 mem_if_ext_pkg::MA_RI_R, mem_if_ext_pkg::MA_RI_W}) begin
      m_stb = 1'b1;
      m_we = is_wr;
      // ri zero extended into the low page
      if (mem_act == mem_if_ext_pkg::MA_DPTR_R || mem_act == mem_if_ext_pkg::MA_DPTR_W) begin
        m_adr = dptr;
      end else begin
        m_adr = {8'h00, src.ri};
      end
      m_dat = is_wr ? acc : 8'h00;
      m_req_known = 1'b1;
    end
  endtask

  task automatic run_cycle(input bit allow_issue);
    @(negedge clk);
    drive_inputs(allow_issue);
    // halfway to the rising edge, all inputs settled
    #1;
    check_outputs();
    advance_model();
  endtask

  initial begin
    seed = 52103;
    clk = 1'b0;
    rst = 1'b1;
    rd_sel = mem_if_ram_pkg::RD_RN;
    wr_sel = mem_if_ram_pkg::WR_RN;
    src = '0;
    mem_act = mem_if_ext_pkg::MA_NONE;
    dptr = '0;
    acc = '0;
    in_ram = '0;
    bit_in = 1'b0;
    sfr = '0;
    sfr_bit = 1'b0;
    dack = 1'b0;
    ddat = '0;
    // reset values
    prev_rd_sel = mem_if_ram_pkg::RD_RN;
    prev_hi = 1'b0;
    prev_rn = '0;
    prev_ri = '0;
    prev_imm = '0;
    prev_imm2 = '0;
    m_stb = 1'b0;
    m_we = 1'b0;
    m_adr = '0;
    m_dat = '0;
    m_req_known = 1'b0;
    m_rdata = '0;
    m_rvalid = 1'b0;
    busy = 1'b0;
    ack_armed = 1'b0;
    ack_cnt = '0;
    issued = 0;
    acked = 0;
    last_dstb = 1'b0;
    stb_starts = 0;
    valid_pulses = 0;
    cyc_n = 0;
    check_errors = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    while (cyc_n < ADDR_CYCLES || issued < ACCESSES || busy) begin
      run_cycle(1'b1);
      cyc_n++;
    end
    // last read return still in flight
    repeat (2) run_cycle(1'b0);
    check_value("dstb_o rising edges", 16'(stb_starts), 16'(ACCESSES));
    check_value("rdata_valid_o pulses", 16'(valid_pulses), 16'(ACCESSES));
    asrt_fails = i_mem_if_top.u_mem_if_assertions.fail_cnt;
    $display("check errors: %0d, assertion failures: %0d", check_errors, asrt_fails);
    if (check_errors == 0 && asrt_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/mem_if_ram_pkg.sv
source/mem_if_ext_pkg.sv
source/ram_addr_select.sv
source/ext_data_access.sv
source/mem_if_top.sv
test/mem_if_assertions.sv
test/mem_if_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_if_tb -f files.f -o mem_if_sim

# keep running after an assertion error so the testbench can report it
./obj_dir/mem_if_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1
